/* source/cpuPkg.sv */
package cpuPkg;

    localparam int XLEN = 32;

    // Microstates of the multicycle sequence
    typedef enum logic [3:0] {
        IF, ID, ID_ECALL, EX_R, EX_IALU, WB_ALU, EX_LDSD, MEM_LD,
        WB_LD, MEM_SD, EX_JAL, EX_JALR, EX_B1, EX_B2, HALT
    } stateT;

    typedef enum logic [1:0] {
        ADD    = 2'b00,
        BRANCH = 2'b01,
        FUNCT  = 2'b10
    } aluOpT;

    typedef enum logic [1:0] {
        REG_B = 2'b00,
        FOUR  = 2'b01,
        IMM   = 2'b10
    } srcBT;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sFmt;
        struct packed {
            logic       immSign;
            logic [5:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] immLo;
            logic       immBit11;
            logic [6:0] opcode;
        } bFmt;
        logic [31:0] raw;
    } instrU;

    typedef struct packed {
        logic  pcWriteNotCond;
        logic  pcWrite;
        logic  iOrD;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  irWrite;
        logic  pcSource;
        aluOpT aluOp;
        srcBT  aluSrcB;
        logic  aluSrcA;
        logic  regWrite;
    } ctrlT;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } memReqT;

endpackage

/* source/regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic                    clk,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    we,
    input  logic [cpuPkg::XLEN-1:0] wdata,
    output logic [cpuPkg::XLEN-1:0] rdata1,
    output logic [cpuPkg::XLEN-1:0] rdata2
);
    import cpuPkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* source/immGen.sv */
`timescale 1ns/10ps

module immGen (
    input  cpuPkg::instrU           instr,
    output logic [cpuPkg::XLEN-1:0] imm
);
    import cpuPkg::*;

    always_comb begin
        case (instr.rFmt.opcode)
            OP_STORE: begin
                imm = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
            end
            OP_BRANCH: begin
                imm = {{19{instr.bFmt.immSign}}, instr.bFmt.immSign, instr.bFmt.immBit11,
                       instr.bFmt.immHi, instr.bFmt.immLo, 1'b0};
            end
            // J format has no view of its own
            OP_JAL: begin
                imm = {{11{instr.raw[31]}}, instr.raw[31], instr.raw[19:12],
                       instr.raw[20], instr.raw[30:21], 1'b0};
            end
            default: begin
                imm = {{20{instr.iFmt.imm12[11]}}, instr.iFmt.imm12};
            end
        endcase
    end

endmodule

/* source/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
    input  logic [cpuPkg::XLEN-1:0] pc,
    input  logic [cpuPkg::XLEN-1:0] a,
    input  logic [cpuPkg::XLEN-1:0] b,
    input  logic [cpuPkg::XLEN-1:0] imm,
    input  logic                    aluSrcA,
    input  cpuPkg::srcBT            aluSrcB,
    input  cpuPkg::aluOpT           aluOp,
    input  cpuPkg::instrU           instr,
    output logic [cpuPkg::XLEN-1:0] result,
    output logic                    branchTaken
);
    import cpuPkg::*;

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lessThan;
    logic            isSub;

    always_comb begin
        opA = aluSrcA ? a : pc;
        case (aluSrcB)
            FOUR:    opB = XLEN'(4);
            IMM:     opB = imm;
            default: opB = b;
        endcase
    end

    assign sum = opA + opB;
    assign diff = opA - opB;
    assign lessThan = $signed(opA) < $signed(opB);
    // addi has no subtract form, so funct7 only counts for R-type
    assign isSub = (instr.rFmt.opcode == OP_R) && instr.rFmt.funct7[5];

    always_comb begin
        result = sum;
        branchTaken = 1'b0;
        case (aluOp)
            FUNCT: begin
                case (instr.rFmt.funct3)
                    3'b000:  result = isSub ? diff : sum;
                    3'b010:  result = {{(XLEN-1){1'b0}}, lessThan};
                    3'b100:  result = opA ^ opB;
                    3'b110:  result = opA | opB;
                    3'b111:  result = opA & opB;
                    default: result = sum;
                endcase
            end
            BRANCH: begin
                result = diff;
                case (instr.rFmt.funct3)
                    3'b000:  branchTaken = (diff == '0);
                    3'b001:  branchTaken = (diff != '0);
                    3'b100:  branchTaken = lessThan;
                    3'b101:  branchTaken = !lessThan;
                    default: branchTaken = 1'b0;
                endcase
            end
            default: result = sum;
        endcase
    end

endmodule

/* source/stateSequencer.sv */
`timescale 1ns/10ps

module stateSequencer (
    input  logic          clk,
    input  logic          rst,
    input  cpuPkg::instrU instr,
    input  logic          accessDone,
    input  logic          branchTaken,
    output cpuPkg::stateT state,
    output logic          halted
);
    import cpuPkg::*;

    stateT nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IF;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            // Memory states wait for the handshake to finish
            IF: if (accessDone) nextState = ID;
            ID: begin
                case (instr.rFmt.opcode)
                    OP_R:               nextState = EX_R;
                    OP_IMM:             nextState = EX_IALU;
                    OP_LOAD, OP_STORE:  nextState = EX_LDSD;
                    OP_JAL:             nextState = EX_JAL;
                    OP_JALR:            nextState = EX_JALR;
                    OP_BRANCH:          nextState = EX_B1;
                    OP_SYSTEM:          nextState = ID_ECALL;
                    default:            nextState = HALT;
                endcase
            end
            ID_ECALL: nextState = HALT;
            EX_R, EX_IALU: nextState = WB_ALU;
            WB_ALU: nextState = IF;
            EX_LDSD: begin
                if (instr.rFmt.opcode == OP_LOAD) begin
                    nextState = MEM_LD;
                end else begin
                    nextState = MEM_SD;
                end
            end
            MEM_LD: if (accessDone) nextState = WB_LD;
            WB_LD: nextState = IF;
            MEM_SD: if (accessDone) nextState = IF;
            EX_JAL, EX_JALR: nextState = IF;
            // Taken branches need the extra PC + imm step
            EX_B1: nextState = branchTaken ? EX_B2 : IF;
            EX_B2: nextState = IF;
            default: nextState = HALT;
        endcase
    end

    assign halted = (state == HALT);

    haltSticky: assert property (@(posedge clk) disable iff (rst)
        state == HALT |=> state == HALT)
        else $error("core left HALT without a reset");

endmodule

/* source/stateToControl.sv */
`timescale 1ns/10ps

module stateToControl (
    input  cpuPkg::stateT state,
    output cpuPkg::ctrlT  ctrl
);
    import cpuPkg::*;

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = ADD;
        ctrl.aluSrcB = REG_B;

        case (state)
            // IR <- MEM[PC]
            IF: begin
                ctrl.iOrD = 1'b0;
                ctrl.memRead = 1'b1;
                ctrl.irWrite = 1'b1;
            end

            // Operands latched, ALUOut <- PC + 4
            ID: begin
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = FOUR;
                ctrl.aluOp = ADD;
            end

            // PC <- PC + 4 before halting
            ID_ECALL: begin
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = FOUR;
                ctrl.pcSource = 1'b0;
                ctrl.pcWrite = 1'b1;
            end

            EX_R: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = REG_B;
                ctrl.aluOp = FUNCT;
            end

            EX_IALU: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = IMM;
                ctrl.aluOp = FUNCT;
            end

            // RF[rd] <- ALUOut and PC <- PC + 4
            WB_ALU: begin
                ctrl.memToReg = 1'b0;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = FOUR;
                ctrl.pcWrite = 1'b1;
            end

            // Effective address A + imm
            EX_LDSD: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = IMM;
                ctrl.aluOp = ADD;
            end

            MEM_LD: begin
                ctrl.iOrD = 1'b1;
                ctrl.memRead = 1'b1;
            end

            WB_LD: begin
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = FOUR;
                ctrl.pcWrite = 1'b1;
            end

            // PC advances only when the write is acknowledged
            MEM_SD: begin
                ctrl.iOrD = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = FOUR;
                ctrl.pcWrite = 1'b1;
            end

            // Link value comes from ALUOut, set in ID
            EX_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = IMM;
                ctrl.pcWrite = 1'b1;
            end

            EX_JALR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = IMM;
                ctrl.pcWrite = 1'b1;
            end

            // Not taken: PC <- ALUOut, which still holds PC + 4
            EX_B1: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = REG_B;
                ctrl.aluOp = BRANCH;
                ctrl.pcSource = 1'b1;
                ctrl.pcWriteNotCond = 1'b1;
            end

            EX_B2: begin
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = IMM;
                ctrl.pcWrite = 1'b1;
            end

            default: ;
        endcase
    end

    always_comb begin
        pcStrobeExclusive: assert (!(ctrl.pcWrite && ctrl.pcWriteNotCond))
            else $error("both PC write strobes active in state %s", state.name());
    end

endmodule

/* source/dataPath.sv */
`timescale 1ns/10ps

module dataPath (
    input  logic                    clk,
    input  logic                    rst,
    input  cpuPkg::ctrlT            ctrl,
    input  logic                    memAck,
    input  logic [cpuPkg::XLEN-1:0] memRdata,
    output cpuPkg::memReqT          memReq,
    output cpuPkg::instrU           instr,
    output logic                    branchTaken,
    output logic                    accessDone
);
    import cpuPkg::*;

    logic [XLEN-1:0] pc;
    instrU           ir;
    logic [XLEN-1:0] regA;
    logic [XLEN-1:0] regB;
    logic [XLEN-1:0] aluOut;
    logic [XLEN-1:0] mdr;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] wbData;
    logic [XLEN-1:0] pcNext;
    logic            memPhase;
    logic            stepDone;
    logic            pcEn;
    logic            raiseReq;
    logic            reqQ;
    logic            weQ;
    logic [XLEN-1:0] addrQ;
    logic [XLEN-1:0] wdataQ;

    assign memPhase = ctrl.memRead | ctrl.memWrite;
    assign accessDone = reqQ & memAck;
    // Strobes of a memory state take effect only on the completing edge
    assign stepDone = !memPhase || accessDone;
    assign pcEn = (ctrl.pcWrite | (ctrl.pcWriteNotCond & !branchTaken)) & stepDone;
    assign pcNext = ctrl.pcSource ? aluOut : {aluResult[XLEN-1:1], 1'b0};
    assign wbData = ctrl.memToReg ? mdr : aluOut;
    assign instr = ir;

    regFile regs (
        .clk(clk), .rs1(ir.rFmt.rs1), .rs2(ir.rFmt.rs2), .rd(ir.rFmt.rd),
        .we(ctrl.regWrite & stepDone), .wdata(wbData), .rdata1(rdata1), .rdata2(rdata2)
    );

    immGen imms (.instr(ir), .imm(imm));

    aluUnit alu (
        .pc(pc), .a(regA), .b(regB), .imm(imm), .aluSrcA(ctrl.aluSrcA),
        .aluSrcB(ctrl.aluSrcB), .aluOp(ctrl.aluOp), .instr(ir),
        .result(aluResult), .branchTaken(branchTaken)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pcEn) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite && accessDone) ir <= memRdata;
        if (ctrl.memRead && ctrl.iOrD && accessDone) mdr <= memRdata;
        // ALUOut keeps the load/store address through the memory wait
        if (!memPhase) begin
            regA <= rdata1;
            regB <= rdata2;
            aluOut <= aluResult;
        end
    end

    // Four-phase request, new req only once ack has dropped
    assign raiseReq = !reqQ && memPhase && !memAck;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqQ <= 1'b0;
        end else if (reqQ) begin
            if (memAck) reqQ <= 1'b0;
        end else if (raiseReq) begin
            reqQ <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (raiseReq) begin
            addrQ <= ctrl.iOrD ? aluOut : pc;
            weQ <= ctrl.memWrite;
            wdataQ <= regB;
        end
    end

    assign memReq = '{req: reqQ, we: weQ, addr: addrQ, wdata: wdataQ};

    reqHoldsAddr: assert property (@(posedge clk) disable iff (rst)
        reqQ && !memAck |=> reqQ && $stable(addrQ) && $stable(weQ))
        else $error("request dropped or changed before ack");

    pcWordAligned: assert property (@(posedge clk) disable iff (rst)
        pcEn |=> pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

/* source/cpuTop.sv */
`timescale 1ns/10ps

module cpuTop (
    input  logic                    clk,
    input  logic                    rst,
    output cpuPkg::memReqT          memReq,
    input  logic                    memAck,
    input  logic [cpuPkg::XLEN-1:0] memRdata,
    output logic                    halted
);
    import cpuPkg::*;

    stateT state;
    ctrlT  ctrl;
    instrU instr;
    logic  branchTaken;
    logic  accessDone;

    stateSequencer sequencer (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .accessDone(accessDone),
        .branchTaken(branchTaken),
        .state(state),
        .halted(halted)
    );

    stateToControl control (
        .state(state),
        .ctrl(ctrl)
    );

    dataPath datapath (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .memAck(memAck),
        .memRdata(memRdata),
        .memReq(memReq),
        .instr(instr),
        .branchTaken(branchTaken),
        .accessDone(accessDone)
    );

endmodule

/* tests/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb;
    import cpuPkg::*;

    localparam int PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int PROGRAMS = 3;
    localparam int MAX_INSTR = 60;
    localparam int CYCLES_PER_INSTR = 12;
    localparam int RAND_INSTR = 40;
    localparam int ECALL_WORD = 7 + RAND_INSTR + 7;
    localparam int MEM_WORDS = 1024;
    localparam int WATCHDOG_CYCLES = PROGRAMS * MAX_INSTR * CYCLES_PER_INSTR
                                     + (PROGRAMS + 1) * (RESET_CYCLES + 3) + PROGRAMS * 10;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
    } accessT;

    logic        clk;
    logic        rst = 1'b1;
    logic        memAck = 1'b0;
    logic [31:0] memRdata = '0;
    logic        halted;
    memReqT      memReq;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] image [0:MEM_WORDS-1];
    logic [31:0] modelMem [0:MEM_WORDS-1];
    logic        loadImage = 1'b0;
    accessT      expQ [$];
    int          expIdx = 0;
    int          accessCount = 0;
    int          delay = 0;
    integer      seed = 32'he817;
    integer      delaySeed = 32'he817;
    string       testName = "reset";
    int          accessErrors = 0;
    int          protocolErrors = 0;
    int          runErrors = 0;
    logic        prevReq;
    logic        prevAck;
    logic        prevWe;
    logic [31:0] prevAddr;

    cpuTop DUT (
        .clk(clk),
        .rst(rst),
        .memReq(memReq),
        .memAck(memAck),
        .memRdata(memRdata),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic int unsigned pick(inout integer s, input int unsigned n);
        return $unsigned($random(s)) % n;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Seeds x1..x7, random body with forward control flow, store block, ecall
    task automatic buildProgram();
        logic [2:0] aluF3 [0:4] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7};
        logic [2:0] brF3 [0:3] = '{3'd0, 3'd1, 3'd4, 3'd5};
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        int         room;
        int         k;
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = 32'h5a5a0000 ^ (i * 32'h9e3779b1);
        end
        for (int r = 1; r < 8; r++) begin
            image[r-1] = encI(12'(pick(seed, 4096)), 5'd0, 3'b000, 5'(r), OP_IMM);
        end
        for (int p = 7; p < 7 + RAND_INSTR; p++) begin
            rd = 5'(pick(seed, 8));
            rs1 = 5'(pick(seed, 8));
            rs2 = 5'(pick(seed, 8));
            f3 = aluF3[pick(seed, 5)];
            room = ECALL_WORD - p;
            k = 1 + int'(pick(seed, (room < 4) ? room : 4));
            case (pick(seed, 8))
                1: image[p] = encI(12'(pick(seed, 4096)), rs1, f3, rd, OP_IMM);
                2: image[p] = encI(12'h400 + 12'(4 * pick(seed, 64)), 5'd0, 3'b010, rd,
                                   OP_LOAD);
                3: image[p] = encS(12'h400 + 12'(4 * pick(seed, 64)), rs2, 5'd0);
                4: image[p] = encJ(21'(4 * k), rd);
                5: image[p] = encI(12'(4 * (p + k)), 5'd0, 3'b000, rd, OP_JALR);
                6: image[p] = encB(13'(4 * k), rs2, rs1, brF3[pick(seed, 4)]);
                default: begin
                    f7 = (f3 == 3'd0 && pick(seed, 2) == 1) ? 7'h20 : 7'h00;
                    image[p] = encR(f7, rs2, rs1, f3, rd);
                end
            endcase
        end
        for (int r = 1; r < 8; r++) begin
            image[7 + RAND_INSTR + r - 1] = encS(12'h500 + 12'(4 * r), 5'(r), 5'd0);
        end
        image[ECALL_WORD] = 32'h00000073;
    endtask

    // Instruction-set model, produces the expected access stream
    task automatic runModel();
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm;
        logic [31:0] addr;
        logic        taken;
        int          steps;
        expQ.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        steps = 0;
        while (steps < 200) begin
            ins = modelMem[pc[11:2]];
            expQ.push_back('{we: 1'b0, addr: pc, data: 32'd0});
            steps++;
            if (ins[6:0] == OP_SYSTEM) break;
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            imm = {{20{ins[31]}}, ins[31:20]};
            case (ins[6:0])
                OP_R, OP_IMM: begin
                    if (ins[6:0] == OP_IMM) b = imm;
                    case (ins[14:12])
                        3'd0: res = (ins[6:0] == OP_R && ins[30]) ? a - b : a + b;
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                    regs[ins[11:7]] = res;
                    pc = pc + 32'd4;
                end
                OP_LOAD: begin
                    addr = a + imm;
                    expQ.push_back('{we: 1'b0, addr: addr, data: 32'd0});
                    regs[ins[11:7]] = modelMem[addr[11:2]];
                    pc = pc + 32'd4;
                end
                OP_STORE: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    expQ.push_back('{we: 1'b1, addr: addr, data: b});
                    modelMem[addr[11:2]] = b;
                    pc = pc + 32'd4;
                end
                OP_JAL: begin
                    regs[ins[11:7]] = pc + 32'd4;
                    pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                OP_JALR: begin
                    addr = (a + imm) & ~32'd1;
                    regs[ins[11:7]] = pc + 32'd4;
                    pc = addr;
                end
                default: begin
                    case (ins[14:12])
                        3'd0: taken = (a == b);
                        3'd1: taken = (a != b);
                        3'd4: taken = ($signed(a) < $signed(b));
                        default: taken = ($signed(a) >= $signed(b));
                    endcase
                    imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    pc = taken ? pc + imm : pc + 32'd4;
                end
            endcase
            // x0 stays zero whatever was written
            regs[0] = '0;
        end
    endtask

    task automatic checkAccess(input memReqT r);
        accessT e;
        assert (expIdx < expQ.size()) else begin
            accessErrors++;
            $display("%s: unexpected memory access to %h after the program end", testName,
                     r.addr);
        end
        if (expIdx < expQ.size()) begin
            e = expQ[expIdx];
            expIdx++;
            assert (r.we == e.we && r.addr == e.addr) else begin
                accessErrors++;
                $display("Fail %s access %0d: expected %s %h, actual %s %h", testName,
                         expIdx - 1, e.we ? "write" : "read", e.addr,
                         r.we ? "write" : "read", r.addr);
            end
            if (e.we && r.we) begin
                assert (r.wdata == e.data) else begin
                    accessErrors++;
                    $display("Fail %s store to %h: expected %h, actual %h", testName,
                             e.addr, e.data, r.wdata);
                end
            end
        end
    endtask

    // Memory model with random ack delays in both handshake phases
    always @(posedge clk) begin
        if (rst) begin
            memAck <= 1'b0;
            expIdx = 0;
            delay = int'(pick(delaySeed, 4));
            if (loadImage) begin
                for (int i = 0; i < MEM_WORDS; i++) begin
                    mem[i] = image[i];
                end
            end
        end else if (!memAck) begin
            if (memReq.req) begin
                if (delay == 0) begin
                    memAck <= 1'b1;
                    memRdata <= mem[memReq.addr[11:2]];
                    if (memReq.we) mem[memReq.addr[11:2]] = memReq.wdata;
                    checkAccess(memReq);
                    accessCount++;
                    delay = int'(pick(delaySeed, 4));
                end else begin
                    delay--;
                end
            end
        end else if (!memReq.req) begin
            if (delay == 0) begin
                memAck <= 1'b0;
                delay = int'(pick(delaySeed, 4));
            end else begin
                delay--;
            end
        end
    end

    // Handshake and halt rules
    always @(posedge clk) begin
        if (rst) begin
            prevReq = 1'b0;
            prevAck = 1'b0;
        end else begin
            assert (!(memReq.req && !prevReq && prevAck)) else begin
                protocolErrors++;
                $display("%s: request raised while ack was still high", testName);
            end
            assert (!(memReq.req && prevReq && (memReq.addr != prevAddr || memReq.we != prevWe)))
            else begin
                protocolErrors++;
                $display("%s: address or write enable changed while request was high",
                         testName);
            end
            assert (!(halted && memReq.req)) else begin
                protocolErrors++;
                $display("%s: memory request issued after the core halted", testName);
            end
            prevReq = memReq.req;
            prevAck = memAck;
            prevAddr = memReq.addr;
            prevWe = memReq.we;
        end
    end

    // A fresh reset loads a new program, a mid-program one keeps memory as it is
    task automatic resetCore(input bit fresh);
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        if (fresh) begin
            buildProgram();
            loadImage = 1'b1;
        end
        repeat (2) @(posedge clk);
        loadImage = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            modelMem[i] = mem[i];
        end
        runModel();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!halted) else begin
            runErrors++;
            $display("%s: halted is high right after reset", testName);
        end
    endtask

    initial begin
        int target;
        for (int prog = 0; prog < PROGRAMS; prog++) begin
            testName = $sformatf("program %0d", prog);
            resetCore(1'b1);
            if (prog == 1) begin
                target = accessCount + 20;
                while (accessCount < target) @(posedge clk);
                testName = "program 1 after mid reset";
                resetCore(1'b0);
            end
            while (!halted) @(posedge clk);
            assert (expIdx == expQ.size()) else begin
                runErrors++;
                $display("%s: core halted after %0d of %0d expected accesses", testName,
                         expIdx, expQ.size());
            end
            repeat (10) @(posedge clk);
        end
        $display("Errors: access %0d, protocol %0d, run %0d", accessErrors, protocolErrors,
                 runErrors);
        if (accessErrors + protocolErrors + runErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired while running %s, the core did not halt in time",
                 testName);
        $display("Test failed");
        $finish;
    end

endmodule

/* all.f */
source/cpuPkg.sv
source/regFile.sv
source/immGen.sv
source/aluUnit.sv
source/stateSequencer.sv
source/stateToControl.sv
source/dataPath.sv
source/cpuTop.sv
tests/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpuTb -f all.f -o cpuSim

# The simulation result decides the exit status through the search below
output=$(./obj_dir/cpuSim || true)
echo "$output"
grep -q "Test completed successfully" <<< "$output"
